/* build.f */
lsu_pkg.sv
lsu_lane_align.sv
lsu_mem_unit.sv
lsu_dmmu.sv
lsu_dmem.sv
lsu_top.sv
tb_clkgen.sv
tb_lsu_checker.sv
tb_lsu.sv

/* lsu_dmem.sv */
// Data memory
// Word-wide single-port array with byte write mask and a held
// one-entry response carrying the word after the access
`timescale 1ns/1ps

module lsu_dmem (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               mem_valid,
   output logic               mem_ready,
   input  lsu_pkg::dbus_cmd_t mem_cmd,
   output logic               rsp_valid,
   input  logic               rsp_ready,
   output lsu_pkg::data_t     rsp_data
);

   lsu_pkg::data_t                    mem [lsu_pkg::MEM_WORDS];
   logic [lsu_pkg::WORD_IDX_W-1:0]    word_idx;
   lsu_pkg::data_t                    cur_word;
   lsu_pkg::data_t                    new_word;
   logic                              hs_mem;
   logic                              rsp_vld_r;
   lsu_pkg::data_t                    rsp_data_r;

   // Bits 11:2 pick the word, higher bits alias
   assign word_idx = mem_cmd.addr[2 +: lsu_pkg::WORD_IDX_W];
   assign cur_word = mem[word_idx];

   // Merge enabled lanes into the stored word
   always_comb begin
      for (int b = 0; b < lsu_pkg::BYTES_W; b++) begin
         new_word[8*b +: 8] = mem_cmd.we_msk[b] ? mem_cmd.din[8*b +: 8]
                                                : cur_word[8*b +: 8];
      end
   end

   // No new access while a response waits
   assign mem_ready = ~rsp_vld_r;
   assign hs_mem    = mem_valid & mem_ready;

   // Array write and response capture
   always_ff @(posedge clk) begin
      if (hs_mem) begin
         if (|mem_cmd.we_msk) begin
            mem[word_idx] <= new_word;
         end
         rsp_data_r <= new_word;
      end
   end

   // Response held until taken
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rsp_vld_r <= 1'b0;
      end else if (hs_mem) begin
         rsp_vld_r <= 1'b1;
      end else if (rsp_ready) begin
         rsp_vld_r <= 1'b0;
      end
   end

   assign rsp_valid = rsp_vld_r;
   assign rsp_data  = rsp_data_r;

endmodule

/* lsu_dmmu.sv */
// Data MMU
// Four-entry page table and one command register; raises TLB miss or
// page fault a cycle after acceptance, else forwards the command to memory
`timescale 1ns/1ps

module lsu_dmmu (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 cfg_we,
   input  lsu_pkg::page_idx_t   cfg_idx,
   input  lsu_pkg::page_entry_t cfg_entry,
   input  logic                 cmd_valid,
   output logic                 cmd_ready,
   input  lsu_pkg::dbus_cmd_t   cmd,
   output logic                 tlb_miss,
   output logic                 page_fault,
   output logic                 mem_valid,
   input  logic                 mem_ready,
   output lsu_pkg::dbus_cmd_t   mem_cmd
);

   lsu_pkg::page_entry_t page_tbl [lsu_pkg::PAGES];
   lsu_pkg::dbus_cmd_t   cmd_r;
   logic                 cmd_vld_r;
   lsu_pkg::page_idx_t   pg_idx;
   lsu_pkg::page_entry_t pg_entry;
   logic                 is_store;

   // Page table, valid bits cleared at reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < lsu_pkg::PAGES; i++) begin
            page_tbl[i] <= '0;
         end
      end else if (cfg_we) begin
         page_tbl[cfg_idx] <= cfg_entry;
      end
   end

   // Register is free when empty
   assign cmd_ready = ~cmd_vld_r;

   // Lookup of the held command
   assign pg_idx   = cmd_r.addr[lsu_pkg::PAGE_IDX_LO +: lsu_pkg::PAGE_IDX_W];
   assign pg_entry = page_tbl[pg_idx];
   assign is_store = |cmd_r.we_msk;

   // Miss wins over fault
   assign tlb_miss   = cmd_vld_r & ~pg_entry.valid;
   assign page_fault = cmd_vld_r & pg_entry.valid & is_store & ~pg_entry.writable;
   assign mem_valid  = cmd_vld_r & pg_entry.valid & (~is_store | pg_entry.writable);
   assign mem_cmd    = cmd_r;

   // Command occupancy
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cmd_vld_r <= 1'b0;
      end else if (cmd_valid & cmd_ready) begin
         cmd_vld_r <= 1'b1;
      end else if (tlb_miss | page_fault | (mem_valid & mem_ready)) begin
         cmd_vld_r <= 1'b0;
      end
   end

   // Command payload
   always_ff @(posedge clk) begin
      if (cmd_valid & cmd_ready) begin
         cmd_r <= cmd;
      end
   end

endmodule

/* lsu_lane_align.sv */
// Byte lane alignment
// Builds the store mask and replicated store data, extracts and extends loads
`timescale 1ns/1ps

module lsu_lane_align (
   input  logic [1:0]          addr_lo,
   input  logic                store,
   input  lsu_pkg::size_t      store_size,
   input  lsu_pkg::size_t      load_size,
   input  logic                sign_ext,
   input  lsu_pkg::data_t      store_src,
   input  lsu_pkg::data_t      rsp_data,
   output lsu_pkg::byte_msk_t  we_msk,
   output lsu_pkg::data_t      store_data,
   output lsu_pkg::data_t      load_data
);

   logic [7:0]  ld_byte;
   logic [15:0] ld_half;

   // Store mask stays zero for loads
   always_comb begin
      we_msk = '0;
      if (store) begin
         case (store_size)
            lsu_pkg::SIZE_WORD: we_msk = 4'b1111;
            lsu_pkg::SIZE_HALF: we_msk = addr_lo[1] ? 4'b1100 : 4'b0011;
            lsu_pkg::SIZE_BYTE: we_msk = 4'b0001 << addr_lo;
            default:            we_msk = '0;
         endcase
      end
   end

   // Narrow stores copied to every lane so the mask picks the lane
   always_comb begin
      case (store_size)
         lsu_pkg::SIZE_WORD: store_data = store_src;
         lsu_pkg::SIZE_HALF: store_data = {2{store_src[15:0]}};
         lsu_pkg::SIZE_BYTE: store_data = {4{store_src[7:0]}};
         default:            store_data = '0;
      endcase
   end

   // Addressed byte and half of the response word
   assign ld_byte = rsp_data[8*addr_lo +: 8];
   assign ld_half = addr_lo[1] ? rsp_data[31:16] : rsp_data[15:0];

   // Zero or sign extension
   always_comb begin
      case (load_size)
         lsu_pkg::SIZE_WORD: load_data = rsp_data;
         lsu_pkg::SIZE_HALF: load_data = {{16{sign_ext & ld_half[15]}}, ld_half};
         lsu_pkg::SIZE_BYTE: load_data = {{24{sign_ext & ld_byte[7]}}, ld_byte};
         default:            load_data = '0;
      endcase
   end

endmodule

/* lsu_mem_unit.sv */
// Memory stage control
// Effective address, alignment check, one outstanding command,
// exception vector select and execute/writeback handshakes
`timescale 1ns/1ps

module lsu_mem_unit (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                in_valid,
   output logic                in_ready,
   input  lsu_pkg::mu_op_t     op,
   output logic                cmd_valid,
   input  logic                cmd_ready,
   output lsu_pkg::dbus_cmd_t  cmd,
   input  logic                rsp_valid,
   output logic                rsp_ready,
   input  lsu_pkg::data_t      rsp_data,
   input  logic                tlb_miss,
   input  logic                page_fault,
   output lsu_pkg::data_t      load_data,
   output lsu_pkg::addr_t      lsa,
   output logic                exp_taken,
   output lsu_pkg::exp_tgt_t   exp_tgt,
   output logic                wb_valid,
   input  logic                wb_ready
);

   logic               mem_op;
   lsu_pkg::size_t     acc_size;
   logic               misalign;
   logic               mmu_exp;
   logic               pending_r;
   logic               hs_cmd;
   logic               hs_wb;
   lsu_pkg::vect_t     vect;
   lsu_pkg::byte_msk_t we_msk;
   lsu_pkg::data_t     store_data;

   // Only loads and stores use the data bus
   assign mem_op = op.load | op.store;

   // Effective address
   assign lsa = op.operand_1 + op.operand_2;

   // Natural alignment for the active size
   assign acc_size = op.load ? op.load_size : op.store_size;
   assign misalign = in_valid & mem_op &
                     (((acc_size == lsu_pkg::SIZE_WORD) & (|lsa[1:0])) |
                      ((acc_size == lsu_pkg::SIZE_HALF) & lsa[0]));

   // MMU reports at most one exception per accepted command
   assign mmu_exp = tlb_miss | page_fault;

   assign hs_cmd = cmd_valid & cmd_ready;
   assign hs_wb  = wb_valid & wb_ready;

   // Misaligned or blocked ops never reach the bus
   assign cmd_valid = in_valid & mem_op & ~misalign & ~pending_r;

   // One outstanding command at a time
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending_r <= 1'b0;
      end else if (hs_cmd) begin
         pending_r <= 1'b1;
      end else if (hs_wb | mmu_exp) begin
         pending_r <= 1'b0;
      end
   end

   // Byte lane steering for store data and load result
   lsu_lane_align u_lane_align (
      .addr_lo    (lsa[1:0]),
      .store      (op.store),
      .store_size (op.store_size),
      .load_size  (op.load_size),
      .sign_ext   (op.sign_ext),
      .store_src  (op.operand_3),
      .rsp_data   (rsp_data),
      .we_msk     (we_msk),
      .store_data (store_data),
      .load_data  (load_data)
   );

   assign cmd.addr   = lsa;
   assign cmd.we_msk = we_msk;
   assign cmd.din    = store_data;

   // Misalignment is raised in the issue cycle, MMU faults a cycle after handshake
   assign exp_taken = misalign | (pending_r & mmu_exp);

   // Fixed priority: misalign, then miss, then fault
   always_comb begin
      if (misalign) begin
         vect = lsu_pkg::VECT_EALIGN;
      end else if (tlb_miss) begin
         vect = lsu_pkg::VECT_EDTM;
      end else if (page_fault) begin
         vect = lsu_pkg::VECT_EDPF;
      end else begin
         vect = '0;
      end
   end

   // Target is the vector without its two low bits
   assign exp_tgt = lsu_pkg::exp_tgt_t'(vect[lsu_pkg::VECT_W-1:2]);

   // Non memory ops pass at once, memory ops wait for writeback or exception
   assign in_ready = ~mem_op | hs_wb | exp_taken;

   // Writeback follows the memory response directly
   assign wb_valid  = rsp_valid;
   assign rsp_ready = wb_ready;

endmodule

/* lsu_pkg.sv */
// Load/store unit shared definitions
// Widths, access size codes, exception vectors, page geometry and bus structs
package lsu_pkg;

   // Datapath geometry
   localparam int unsigned ADDR_W = 32;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned BYTES_W = DATA_W / 8;

   typedef logic [ADDR_W-1:0]  addr_t;
   typedef logic [DATA_W-1:0]  data_t;
   typedef logic [BYTES_W-1:0] byte_msk_t;

   // Access size codes as driven by the execute stage
   typedef logic [2:0] size_t;
   localparam size_t SIZE_BYTE = 3'd1;
   localparam size_t SIZE_HALF = 3'd2;
   localparam size_t SIZE_WORD = 3'd3;

   // Exception vectors, target drops the two low bits
   localparam int unsigned VECT_W = 8;
   typedef logic [VECT_W-1:0] vect_t;
   typedef logic [ADDR_W-3:0] exp_tgt_t;
   localparam vect_t VECT_EDTM   = 8'h1c;
   localparam vect_t VECT_EDPF   = 8'h20;
   localparam vect_t VECT_EALIGN = 8'h24;

   // 4 KB data memory, upper address bits alias
   localparam int unsigned MEM_WORDS  = 1024;
   localparam int unsigned WORD_IDX_W = $clog2(MEM_WORDS);

   // Four 1 KB pages selected by address bits 11:10
   localparam int unsigned PAGE_IDX_LO = 10;
   localparam int unsigned PAGE_IDX_W  = 2;
   localparam int unsigned PAGES       = 1 << PAGE_IDX_W;
   typedef logic [PAGE_IDX_W-1:0] page_idx_t;

   typedef struct packed {
      logic valid;
      logic writable;
   } page_entry_t;

   // Decoded memory operation from the execute stage
   typedef struct packed {
      logic  load;
      logic  store;
      logic  sign_ext;
      size_t load_size;
      size_t store_size;
      data_t operand_1;
      data_t operand_2;
      data_t operand_3;
   } mu_op_t;

   // Data bus command, zero mask means read
   typedef struct packed {
      addr_t     addr;
      byte_msk_t we_msk;
      data_t     din;
   } dbus_cmd_t;

endpackage

/* lsu_top.sv */
// Load/store subsystem top
// Memory stage control, data MMU and data memory
`timescale 1ns/1ps

module lsu_top (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 in_valid,
   output logic                 in_ready,
   input  lsu_pkg::mu_op_t      op,
   input  logic                 cfg_we,
   input  lsu_pkg::page_idx_t   cfg_idx,
   input  lsu_pkg::page_entry_t cfg_entry,
   output lsu_pkg::data_t       load_data,
   output lsu_pkg::addr_t       lsa,
   output logic                 exp_taken,
   output lsu_pkg::exp_tgt_t    exp_tgt,
   output logic                 wb_valid,
   input  logic                 wb_ready
);

   // Memory unit to MMU
   logic               cmd_valid;
   logic               cmd_ready;
   lsu_pkg::dbus_cmd_t cmd;
   logic               tlb_miss;
   logic               page_fault;

   // MMU to memory
   logic               mem_valid;
   logic               mem_ready;
   lsu_pkg::dbus_cmd_t mem_cmd;

   // Memory response
   logic               rsp_valid;
   logic               rsp_ready;
   lsu_pkg::data_t     rsp_data;

   lsu_mem_unit u_mem_unit (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .op         (op),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd        (cmd),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp_data   (rsp_data),
      .tlb_miss   (tlb_miss),
      .page_fault (page_fault),
      .load_data  (load_data),
      .lsa        (lsa),
      .exp_taken  (exp_taken),
      .exp_tgt    (exp_tgt),
      .wb_valid   (wb_valid),
      .wb_ready   (wb_ready)
   );

   lsu_dmmu u_dmmu (
      .clk        (clk),
      .arst_n     (arst_n),
      .cfg_we     (cfg_we),
      .cfg_idx    (cfg_idx),
      .cfg_entry  (cfg_entry),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd        (cmd),
      .tlb_miss   (tlb_miss),
      .page_fault (page_fault),
      .mem_valid  (mem_valid),
      .mem_ready  (mem_ready),
      .mem_cmd    (mem_cmd)
   );

   lsu_dmem u_dmem (
      .clk        (clk),
      .arst_n     (arst_n),
      .mem_valid  (mem_valid),
      .mem_ready  (mem_ready),
      .mem_cmd    (mem_cmd),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp_data   (rsp_data)
   );

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the load/store testbench with Verilator, verdict from the log
rm -rf obj_dir run.log
verilator --binary --timing -Wno-fatal --top-module tb_lsu -f build.f -o tb_lsu > run.log 2>&1 \
   && ./obj_dir/tb_lsu >> run.log 2>&1 \
   || echo "sim failed" >> run.log
grep -q "sim failed" run.log && { echo "FAIL, see run.log"; exit 1; } \
   || { echo "PASS"; exit 0; }

/* tb_clkgen.sv */
// Testbench clock and reset
// 4 ns clock, active low reset held for the first 8 cycles
`timescale 1ns/1ps

module tb_clkgen (
   output logic clk,
   output logic arst_n
);

   localparam int HALF_NS    = 2;
   localparam int RST_CYCLES = 8;

   initial begin
      clk = 1'b0;
      forever #HALF_NS clk = ~clk;
   end

   // Release just after an edge so the first driven cycle is clean
   initial begin
      arst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1 arst_n = 1'b1;
   end

endmodule

/* tb_lsu.sv */
// Load/store subsystem testbench
// Page setup and memory operations through the execute-stage port,
// six directed and random tests with a watchdog
`timescale 1ns/1ps

module tb_lsu;

   localparam int CLK_NS     = 4;
   localparam int RST_CYCLES = 8;
   localparam int DRV_NS     = 1;
   // Setup, then per test: ops and page writes
   localparam int N_OPS = 4 + 16 * 2 + 8 * 10 + 4 * 6 + 8 + 16 * 2 + 8;

   logic                 clk;
   logic                 arst_n;
   logic                 in_valid;
   logic                 in_ready;
   lsu_pkg::mu_op_t      op;
   logic                 cfg_we;
   lsu_pkg::page_idx_t   cfg_idx;
   lsu_pkg::page_entry_t cfg_entry;
   lsu_pkg::data_t       load_data;
   lsu_pkg::addr_t       lsa;
   logic                 exp_taken;
   lsu_pkg::exp_tgt_t    exp_tgt;
   logic                 wb_valid;
   logic                 wb_ready;
   logic                 stall_on;
   int                   checks;
   int                   errors;
   int                   chk_mark;
   int                   err_mark;
   logic [11:0]          a;
   logic [11:0]          b;

   tb_clkgen u_clkgen (.clk(clk), .arst_n(arst_n));

   lsu_top u_lsu_top (
      .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_ready(in_ready), .op(op),
      .cfg_we(cfg_we), .cfg_idx(cfg_idx), .cfg_entry(cfg_entry), .load_data(load_data),
      .lsa(lsa), .exp_taken(exp_taken), .exp_tgt(exp_tgt), .wb_valid(wb_valid),
      .wb_ready(wb_ready)
   );

   tb_lsu_checker u_checker (
      .clk(clk), .arst_n(arst_n), .cfg_we(cfg_we), .cfg_idx(cfg_idx),
      .cfg_entry(cfg_entry), .in_valid(in_valid), .in_ready(in_ready), .op(op),
      .lsa(lsa), .load_data(load_data), .exp_taken(exp_taken), .exp_tgt(exp_tgt),
      .wb_valid(wb_valid), .wb_ready(wb_ready), .checks(checks), .errors(errors)
   );

   // Effective address split randomly over both operands, upper bits alias
   function automatic lsu_pkg::mu_op_t make_op(input logic ld, input logic st,
         input lsu_pkg::size_t sz, input logic sx, input logic [11:0] off,
         input lsu_pkg::data_t d);
      lsu_pkg::mu_op_t o;
      lsu_pkg::addr_t  full;
      o            = '0;
      full         = {20'($urandom), off};
      o.load       = ld;
      o.store      = st;
      o.sign_ext   = sx;
      o.load_size  = sz;
      o.store_size = sz;
      o.operand_1  = $urandom;
      o.operand_2  = full - o.operand_1;
      o.operand_3  = d;
      return o;
   endfunction

   // Hold the op until in_ready, wb_ready stalls randomly when enabled
   task automatic issue(input lsu_pkg::mu_op_t o);
      logic acc;
      acc      = 1'b0;
      in_valid = 1'b1;
      op       = o;
      while (!acc) begin
         wb_ready = stall_on ? ($urandom_range(0, 2) != 0) : 1'b1;
         @(negedge clk);
         acc = in_ready;
         @(posedge clk);
         #DRV_NS;
      end
      in_valid = 1'b0;
   endtask

   task automatic store_at(input lsu_pkg::size_t sz, input logic [11:0] off,
                           input lsu_pkg::data_t d);
      issue(make_op(1'b0, 1'b1, sz, 1'b0, off, d));
   endtask

   task automatic load_from(input lsu_pkg::size_t sz, input logic sx, input logic [11:0] off);
      issue(make_op(1'b1, 1'b0, sz, sx, off, $urandom));
   endtask

   task automatic set_page(input int idx, input logic v, input logic w);
      cfg_we             = 1'b1;
      cfg_idx            = lsu_pkg::page_idx_t'(idx);
      cfg_entry.valid    = v;
      cfg_entry.writable = w;
      @(posedge clk);
      #DRV_NS;
      cfg_we = 1'b0;
   endtask

   task automatic end_test(input string name);
      $display("test %-40s %0d checks, %0d errors", name, checks - chk_mark,
               errors - err_mark);
      chk_mark = checks;
      err_mark = errors;
   endtask

   initial begin
      void'($urandom(27026));
      in_valid  = 1'b0;
      op        = '0;
      cfg_we    = 1'b0;
      cfg_idx   = '0;
      cfg_entry = '0;
      wb_ready  = 1'b1;
      stall_on  = 1'b0;
      chk_mark  = 0;
      err_mark  = 0;
      wait (arst_n);
      @(posedge clk);
      #DRV_NS;
      // Pages 0 and 1 writable, 2 read-only, 3 unmapped
      set_page(0, 1'b1, 1'b1);
      set_page(1, 1'b1, 1'b1);
      set_page(2, 1'b1, 1'b0);
      set_page(3, 1'b0, 1'b0);

      for (int i = 0; i < 16; i++) begin
         a = {1'b0, 9'($urandom), 2'b00};
         store_at(lsu_pkg::SIZE_WORD, a, $urandom);
         load_from(lsu_pkg::SIZE_WORD, 1'b0, a);
      end
      end_test("word store and load");

      // Narrow stores merge into a known word, then every lane is read back
      for (int i = 0; i < 8; i++) begin
         a = {1'b0, 9'($urandom), 2'b00};
         store_at(lsu_pkg::SIZE_WORD, a, $urandom);
         store_at(lsu_pkg::SIZE_BYTE, a | 12'($urandom_range(0, 3)), $urandom);
         store_at(lsu_pkg::SIZE_HALF, a | 12'(2 * $urandom_range(0, 1)), $urandom);
         for (int k = 0; k < 4; k++) begin
            load_from(lsu_pkg::SIZE_BYTE, 1'($urandom), a | 12'(k));
         end
         load_from(lsu_pkg::SIZE_HALF, 1'($urandom), a);
         load_from(lsu_pkg::SIZE_HALF, 1'($urandom), a | 12'd2);
         load_from(lsu_pkg::SIZE_WORD, 1'b0, a);
      end
      end_test("byte and half merge and extension");

      for (int i = 0; i < 4; i++) begin
         a = {1'b0, 9'($urandom), 2'b00};
         store_at(lsu_pkg::SIZE_WORD, a, $urandom);
         store_at(lsu_pkg::SIZE_WORD, a | 12'($urandom_range(1, 3)), $urandom);
         store_at(lsu_pkg::SIZE_HALF, a | 12'(2 * $urandom_range(0, 1) + 1), $urandom);
         load_from(lsu_pkg::SIZE_WORD, 1'b0, a | 12'd2);
         load_from(lsu_pkg::SIZE_HALF, 1'b1, a | 12'd3);
         // Word must be untouched by the rejected stores
         load_from(lsu_pkg::SIZE_WORD, 1'b0, a);
      end
      end_test("misaligned access");

      // Seed a word in page 2 before it turns read-only
      set_page(2, 1'b1, 1'b1);
      a = {2'b10, 8'($urandom), 2'b00};
      b = {2'b11, 8'($urandom), 2'b00};
      store_at(lsu_pkg::SIZE_WORD, a, $urandom);
      set_page(2, 1'b1, 1'b0);
      store_at(lsu_pkg::SIZE_WORD, b, $urandom);
      load_from(lsu_pkg::SIZE_HALF, 1'b0, b);
      // Alignment wins over the miss
      load_from(lsu_pkg::SIZE_WORD, 1'b0, b | 12'd1);
      store_at(lsu_pkg::SIZE_BYTE, a | 12'd1, $urandom);
      load_from(lsu_pkg::SIZE_WORD, 1'b0, a);
      end_test("tlb miss and page fault");

      stall_on = 1'b1;
      for (int i = 0; i < 16; i++) begin
         a = {1'b0, 9'($urandom), 2'b00};
         store_at(lsu_pkg::SIZE_WORD, a, $urandom);
         load_from(lsu_pkg::SIZE_BYTE, 1'($urandom), a | 12'($urandom_range(0, 3)));
      end
      stall_on = 1'b0;
      wb_ready = 1'b1;
      end_test("writeback back-pressure");

      for (int i = 0; i < 8; i++) begin
         issue(make_op(1'b0, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, 12'($urandom), $urandom));
      end
      end_test("non-memory operations");

      $display("total %0d checks, %0d errors", checks, errors);
      if (errors == 0 && checks > 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // Generous per-op budget covers back-pressure stalls
   initial begin
      #((N_OPS * 20 + RST_CYCLES) * CLK_NS);
      $display("Timeout: operations stopped completing before the end of the tests");
      $display("sim failed");
      $finish;
   end

endmodule

/* tb_lsu_checker.sv */
// Testbench checker
// Shadow page table and memory, reference result per accepted operation,
// handshake latency and writeback hold checks
`timescale 1ns/1ps

module tb_lsu_checker (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 cfg_we,
   input  lsu_pkg::page_idx_t   cfg_idx,
   input  lsu_pkg::page_entry_t cfg_entry,
   input  logic                 in_valid,
   input  logic                 in_ready,
   input  lsu_pkg::mu_op_t      op,
   input  lsu_pkg::addr_t       lsa,
   input  lsu_pkg::data_t       load_data,
   input  logic                 exp_taken,
   input  lsu_pkg::exp_tgt_t    exp_tgt,
   input  logic                 wb_valid,
   input  logic                 wb_ready,
   output int                   checks,
   output int                   errors
);

   // Expected outcome of one operation
   typedef struct packed {
      logic              mem;
      logic              exc;
      lsu_pkg::exp_tgt_t tgt;
      lsu_pkg::addr_t    addr;
      lsu_pkg::data_t    data;
      logic [1:0]        lat;
   } expect_t;

   lsu_pkg::page_entry_t pt [lsu_pkg::PAGES];
   lsu_pkg::data_t       shadow [lsu_pkg::MEM_WORDS];
   expect_t              exp_r;
   int                   cyc;
   logic                 held;
   lsu_pkg::data_t       held_data;

   // Priority: misalignment, then miss, then fault
   function automatic expect_t expected_result(input lsu_pkg::mu_op_t o);
      expect_t              e;
      lsu_pkg::size_t       sz;
      lsu_pkg::page_entry_t pg;
      lsu_pkg::data_t       sh;
      e      = '0;
      e.mem  = o.load | o.store;
      e.addr = o.operand_1 + o.operand_2;
      sz     = o.load ? o.load_size : o.store_size;
      pg     = pt[e.addr[lsu_pkg::PAGE_IDX_LO +: lsu_pkg::PAGE_IDX_W]];
      // Addressed lane moved down to bit 0
      sh = shadow[e.addr[2 +: lsu_pkg::WORD_IDX_W]] >> (8 * e.addr[1:0]);
      if (!e.mem) begin
         e.lat = 2'd0;
      end else if ((sz == lsu_pkg::SIZE_WORD && e.addr[1:0] != 2'd0) ||
                   (sz == lsu_pkg::SIZE_HALF && e.addr[0])) begin
         e.exc = 1'b1;
         e.tgt = lsu_pkg::exp_tgt_t'(lsu_pkg::VECT_EALIGN >> 2);
      end else if (!pg.valid) begin
         e.exc = 1'b1;
         e.tgt = lsu_pkg::exp_tgt_t'(lsu_pkg::VECT_EDTM >> 2);
         e.lat = 2'd1;
      end else if (o.store && !pg.writable) begin
         e.exc = 1'b1;
         e.tgt = lsu_pkg::exp_tgt_t'(lsu_pkg::VECT_EDPF >> 2);
         e.lat = 2'd1;
      end else begin
         e.lat = 2'd2;
         if (sz == lsu_pkg::SIZE_BYTE) begin
            e.data = sh & 32'h0000_00ff;
            if (o.sign_ext && sh[7])
               e.data = e.data | 32'hffff_ff00;
         end else if (sz == lsu_pkg::SIZE_HALF) begin
            e.data = sh & 32'h0000_ffff;
            if (o.sign_ext && sh[15])
               e.data = e.data | 32'hffff_0000;
         end else begin
            e.data = sh;
         end
      end
      return e;
   endfunction

   // Write the stored bytes into the shadow word, low source byte first
   task automatic apply_store(input lsu_pkg::mu_op_t o, input lsu_pkg::addr_t a);
      int nb;
      nb = (o.store_size == lsu_pkg::SIZE_WORD) ? 4 :
           (o.store_size == lsu_pkg::SIZE_HALF) ? 2 : 1;
      for (int k = 0; k < nb; k++) begin
         shadow[a[2 +: lsu_pkg::WORD_IDX_W]][8 * (int'(a[1:0]) + k) +: 8] =
            o.operand_3[8 * k +: 8];
      end
   endtask

   task automatic compare_value(input string name, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
      checks++;
      if (act_v !== exp_v) begin
         errors++;
         $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
      end
   endtask

   task automatic report_fault(input string msg);
      errors++;
      $display("Failure at %0t: %s", $time, msg);
   endtask

   // Sampled mid-cycle, well clear of the drive edge
   always @(negedge clk) begin
      if (!arst_n) begin
         for (int i = 0; i < lsu_pkg::PAGES; i++) begin
            pt[i] = '0;
         end
         cyc    = 0;
         held   = 1'b0;
         checks = 0;
         errors = 0;
      end else begin
         if (cfg_we) begin
            pt[cfg_idx] = cfg_entry;
         end
         // Back-pressure must hold valid and data
         if (held && !wb_valid) begin
            report_fault("wb_valid dropped while wb_ready was low");
         end else if (held) begin
            compare_value("load_data", held_data, load_data);
         end
         if (wb_valid && !in_valid) begin
            report_fault("wb_valid raised with no operation presented");
         end
         if (wb_valid && !held && cyc != 2) begin
            report_fault($sformatf("wb_valid came %0d cycles after issue, not 2", cyc));
         end
         if (in_valid && in_ready) begin
            exp_r = expected_result(op);
            compare_value("exp_taken", 32'(exp_r.exc), 32'(exp_taken));
            if (!exp_r.mem) begin
               compare_value("wb_valid", 32'd0, 32'(wb_valid));
               if (cyc != 0)
                  report_fault("non-memory operation waited for in_ready");
            end else if (exp_r.exc) begin
               compare_value("exp_tgt", 32'(exp_r.tgt), 32'(exp_tgt));
               compare_value("wb_valid", 32'd0, 32'(wb_valid));
               if (cyc != int'(exp_r.lat))
                  report_fault($sformatf("exception came after %0d cycles, not %0d",
                                         cyc, exp_r.lat));
            end else begin
               compare_value("lsa", exp_r.addr, lsa);
               compare_value("wb_valid", 32'd1, 32'(wb_valid));
               if (op.load)
                  compare_value("load_data", exp_r.data, load_data);
               else
                  apply_store(op, exp_r.addr);
            end
            cyc = 0;
         end else if (in_valid) begin
            cyc++;
         end
         held      = wb_valid & ~wb_ready;
         held_data = load_data;
      end
   end

endmodule
